// File: src/cache_params.svh
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

`define CACHE_NUM_REQS        2
`define CACHE_NUM_BANKS       2
`define CACHE_WORD_BYTES      4
`define CACHE_LINE_WORDS      4
`define CACHE_LINES_PER_BANK  8
`define CACHE_ADDR_WIDTH      12
`define CACHE_TAG_WIDTH       4

`define CACHE_WORD_WIDTH      (`CACHE_WORD_BYTES * 8)
`define CACHE_WORD_SEL_BITS   $clog2(`CACHE_LINE_WORDS)
`define CACHE_BANK_SEL_BITS   $clog2(`CACHE_NUM_BANKS)
`define CACHE_INDEX_BITS      $clog2(`CACHE_LINES_PER_BANK)

// Line tag kept per bank entry
`define CACHE_LTAG_BITS       (`CACHE_ADDR_WIDTH - `CACHE_WORD_SEL_BITS \
                               - `CACHE_BANK_SEL_BITS - `CACHE_INDEX_BITS)

`define CACHE_MEM_ADDR_WIDTH  (`CACHE_ADDR_WIDTH - `CACHE_WORD_SEL_BITS)

// Index widths, at least one bit
`define CACHE_REQ_SEL_WIDTH   ((`CACHE_NUM_REQS > 1) ? $clog2(`CACHE_NUM_REQS) : 1)
`define CACHE_BANK_ID_WIDTH   ((`CACHE_NUM_BANKS > 1) ? $clog2(`CACHE_NUM_BANKS) : 1)

`endif

// File: src/cache_pkg.sv
`include "cache_params.svh"

package cache_pkg;

    typedef logic [`CACHE_WORD_WIDTH-1:0] word_t;
    typedef logic [`CACHE_WORD_BYTES-1:0] byteen_t;

    typedef logic [`CACHE_LINE_WORDS-1:0][`CACHE_WORD_WIDTH-1:0] line_t;
    typedef logic [`CACHE_LINE_WORDS-1:0][`CACHE_WORD_BYTES-1:0] line_byteen_t;

    typedef logic [`CACHE_ADDR_WIDTH-1:0]     core_addr_t;
    typedef logic [`CACHE_MEM_ADDR_WIDTH-1:0] mem_addr_t;
    typedef logic [`CACHE_TAG_WIDTH-1:0]      req_tag_t;
    typedef logic [`CACHE_REQ_SEL_WIDTH-1:0]  req_idx_t;
    typedef logic [`CACHE_BANK_ID_WIDTH-1:0]  bank_id_t;

    // Request crossbar payload
    typedef struct packed {
        logic       rw;
        core_addr_t addr;
        byteen_t    byteen;
        word_t      data;
        req_tag_t   tag;
    } core_req_t;

    // Response crossbar payload
    typedef struct packed {
        word_t    data;
        req_tag_t tag;
    } core_rsp_t;

endpackage

// File: src/stream_xbar.sv
`timescale 1ns/1ps

module stream_xbar #(
    parameter int  NUM_INPUTS  = 2,
    parameter int  NUM_OUTPUTS = 2,
    parameter type payload_t   = logic [31:0],
    localparam int SEL_IN_W    = (NUM_OUTPUTS > 1) ? $clog2(NUM_OUTPUTS) : 1,
    localparam int SEL_OUT_W   = (NUM_INPUTS > 1) ? $clog2(NUM_INPUTS) : 1
) (
    input  logic                   clk,
    input  logic                   reset,

    input  logic [NUM_INPUTS-1:0]  valid_in,
    input  payload_t               data_in [NUM_INPUTS],
    input  logic [SEL_IN_W-1:0]    sel_in [NUM_INPUTS],
    output logic [NUM_INPUTS-1:0]  ready_in,

    output logic [NUM_OUTPUTS-1:0] valid_out,
    output payload_t               data_out [NUM_OUTPUTS],
    output logic [SEL_OUT_W-1:0]   sel_out [NUM_OUTPUTS],
    input  logic [NUM_OUTPUTS-1:0] ready_out
);

    // Per-output round-robin start point
    logic [SEL_OUT_W-1:0] rr_ptr [NUM_OUTPUTS];

    always_comb begin
        int idx;
        ready_in  = '0;
        valid_out = '0;
        for (int o = 0; o < NUM_OUTPUTS; o++) begin
            data_out[o] = data_in[0];
            sel_out[o]  = '0;
            // first requester at or after the pointer wins
            for (int k = 0; k < NUM_INPUTS; k++) begin
                idx = (int'(rr_ptr[o]) + k) % NUM_INPUTS;
                if (!valid_out[o] && valid_in[idx] && sel_in[idx] == SEL_IN_W'(o)) begin
                    valid_out[o]  = 1'b1;
                    data_out[o]   = data_in[idx];
                    sel_out[o]    = SEL_OUT_W'(idx);
                    ready_in[idx] = ready_out[o];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int o = 0; o < NUM_OUTPUTS; o++) begin
                rr_ptr[o] <= '0;
            end
        end else begin
            for (int o = 0; o < NUM_OUTPUTS; o++) begin
                if (valid_out[o] && ready_out[o]) begin
                    rr_ptr[o] <= SEL_OUT_W'((int'(sel_out[o]) + 1) % NUM_INPUTS);
                end
            end
        end
    end

endmodule

// File: src/cache_bank.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_bank import cache_pkg::*; (
    input  logic         clk,
    input  logic         reset,

    input  logic         core_req_valid,
    input  core_req_t    core_req,
    input  req_idx_t     core_req_idx,
    output logic         core_req_ready,

    output logic         core_rsp_valid,
    output core_rsp_t    core_rsp,
    output req_idx_t     core_rsp_idx,
    input  logic         core_rsp_ready,

    output logic         mem_req_valid,
    output logic         mem_req_rw,
    output mem_addr_t    mem_req_addr,
    output line_byteen_t mem_req_byteen,
    output line_t        mem_req_data,
    input  logic         mem_req_ready,

    input  logic         mem_rsp_valid,
    input  line_t        mem_rsp_data,
    output logic         mem_rsp_ready
);

    localparam int WSEL_BITS = `CACHE_WORD_SEL_BITS;
    localparam int IDX_LSB   = `CACHE_WORD_SEL_BITS + `CACHE_BANK_SEL_BITS;
    localparam int IDX_BITS  = `CACHE_INDEX_BITS;
    localparam int LTAG_BITS = `CACHE_LTAG_BITS;

    typedef enum logic [1:0] {IDLE, RESPOND, MISS_WAIT, WRITE_OUT} state_t;

    state_t state;
    logic   mem_sent;

    logic [`CACHE_LINES_PER_BANK-1:0] line_valid;
    logic [LTAG_BITS-1:0]             line_tag [`CACHE_LINES_PER_BANK];
    line_t                            line_data [`CACHE_LINES_PER_BANK];

    core_req_t req;
    req_idx_t  req_idx;
    word_t     rsp_data;

    logic [IDX_BITS-1:0]  in_index;
    logic [LTAG_BITS-1:0] in_ltag;
    logic [WSEL_BITS-1:0] in_wsel;
    logic [IDX_BITS-1:0]  req_index;
    logic [LTAG_BITS-1:0] req_ltag;
    logic [WSEL_BITS-1:0] req_wsel;

    logic  hit;
    logic  req_fire;
    logic  fill_fire;
    line_t merged_line;

    assign in_wsel   = core_req.addr[WSEL_BITS-1:0];
    assign in_index  = core_req.addr[IDX_LSB +: IDX_BITS];
    assign in_ltag   = core_req.addr[IDX_LSB + IDX_BITS +: LTAG_BITS];
    assign req_wsel  = req.addr[WSEL_BITS-1:0];
    assign req_index = req.addr[IDX_LSB +: IDX_BITS];
    assign req_ltag  = req.addr[IDX_LSB + IDX_BITS +: LTAG_BITS];

    assign hit       = line_valid[in_index] && (line_tag[in_index] == in_ltag);
    assign req_fire  = core_req_valid && (state == IDLE);
    assign fill_fire = mem_rsp_valid && (state == MISS_WAIT);

    // Write bytes merged into the indexed line
    always_comb begin
        merged_line = line_data[in_index];
        for (int b = 0; b < `CACHE_WORD_BYTES; b++) begin
            if (core_req.byteen[b]) begin
                merged_line[in_wsel][b*8 +: 8] = core_req.data[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            mem_sent   <= 1'b0;
            line_valid <= '0;
        end else begin
            case (state)
                IDLE: begin
                    mem_sent <= 1'b0;
                    if (core_req_valid) begin
                        if (core_req.rw) begin
                            state <= WRITE_OUT;
                        end else if (hit) begin
                            state <= RESPOND;
                        end else begin
                            state <= MISS_WAIT;
                        end
                    end
                end
                RESPOND: begin
                    if (core_rsp_ready) begin
                        state <= IDLE;
                    end
                end
                MISS_WAIT: begin
                    if (mem_req_valid && mem_req_ready) begin
                        mem_sent <= 1'b1;
                    end
                    if (mem_rsp_valid) begin
                        line_valid[req_index] <= 1'b1;
                        state <= RESPOND;
                    end
                end
                default: begin
                    if (mem_req_ready) begin
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            req      <= core_req;
            req_idx  <= core_req_idx;
            rsp_data <= line_data[in_index][in_wsel];
            if (core_req.rw && hit) begin
                line_data[in_index] <= merged_line;
            end
        end
        if (fill_fire) begin
            line_data[req_index] <= mem_rsp_data;
            line_tag[req_index]  <= req_ltag;
            rsp_data             <= mem_rsp_data[req_wsel];
        end
    end

    assign core_req_ready = (state == IDLE);
    assign core_rsp_valid = (state == RESPOND);
    assign core_rsp       = '{data: rsp_data, tag: req.tag};
    assign core_rsp_idx   = req_idx;

    // Bank bits are put back in by the top level
    assign mem_req_valid = (state == WRITE_OUT) || ((state == MISS_WAIT) && !mem_sent);
    assign mem_req_rw    = (state == WRITE_OUT);
    assign mem_req_addr  = mem_addr_t'({req_ltag, req_index});
    assign mem_req_data  = {`CACHE_LINE_WORDS{req.data}};
    assign mem_rsp_ready = (state == MISS_WAIT);

    always_comb begin
        mem_req_byteen = '0;
        if (mem_req_rw) begin
            mem_req_byteen[req_wsel] = req.byteen;
        end
    end

endmodule

// File: src/mem_port_arb.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module mem_port_arb import cache_pkg::*; (
    input  logic                        clk,
    input  logic                        reset,

    input  logic [`CACHE_NUM_BANKS-1:0] bank_req_valid,
    input  logic [`CACHE_NUM_BANKS-1:0] bank_req_rw,
    input  mem_addr_t                   bank_req_addr [`CACHE_NUM_BANKS],
    input  line_byteen_t                bank_req_byteen [`CACHE_NUM_BANKS],
    input  line_t                       bank_req_data [`CACHE_NUM_BANKS],
    output logic [`CACHE_NUM_BANKS-1:0] bank_req_ready,

    output logic [`CACHE_NUM_BANKS-1:0] bank_rsp_valid,
    output line_t                       bank_rsp_data [`CACHE_NUM_BANKS],
    input  logic [`CACHE_NUM_BANKS-1:0] bank_rsp_ready,

    output logic                        mem_req_valid,
    output logic                        mem_req_rw,
    output mem_addr_t                   mem_req_addr,
    output line_byteen_t                mem_req_byteen,
    output line_t                       mem_req_data,
    output bank_id_t                    mem_req_tag,
    input  logic                        mem_req_ready,

    input  logic                        mem_rsp_valid,
    input  line_t                       mem_rsp_data,
    input  bank_id_t                    mem_rsp_tag,
    output logic                        mem_rsp_ready
);

    localparam int NB = `CACHE_NUM_BANKS;

    bank_id_t rr_ptr;
    bank_id_t grant;

    always_comb begin
        int b;
        mem_req_valid = 1'b0;
        grant = rr_ptr;
        for (int k = 0; k < NB; k++) begin
            b = (int'(rr_ptr) + k) % NB;
            if (!mem_req_valid && bank_req_valid[b]) begin
                mem_req_valid = 1'b1;
                grant = bank_id_t'(b);
            end
        end
    end

    assign mem_req_rw     = bank_req_rw[grant];
    assign mem_req_addr   = bank_req_addr[grant];
    assign mem_req_byteen = bank_req_byteen[grant];
    assign mem_req_data   = bank_req_data[grant];
    assign mem_req_tag    = grant;

    always_ff @(posedge clk) begin
        if (reset) begin
            rr_ptr <= '0;
        end else if (mem_req_valid && mem_req_ready) begin
            rr_ptr <= bank_id_t'((int'(grant) + 1) % NB);
        end
    end

    // Fills go back to the bank named by the tag
    for (genvar b = 0; b < NB; b++) begin : g_bank
        assign bank_req_ready[b] = mem_req_ready && mem_req_valid && (grant == bank_id_t'(b));
        assign bank_rsp_valid[b] = mem_rsp_valid && (mem_rsp_tag == bank_id_t'(b));
        assign bank_rsp_data[b]  = mem_rsp_data;
    end

    assign mem_rsp_ready = bank_rsp_ready[mem_rsp_tag];

endmodule

// File: src/banked_cache.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module banked_cache import cache_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,

    input  logic [`CACHE_NUM_REQS-1:0] core_req_valid,
    input  logic [`CACHE_NUM_REQS-1:0] core_req_rw,
    input  core_addr_t                 core_req_addr [`CACHE_NUM_REQS],
    input  byteen_t                    core_req_byteen [`CACHE_NUM_REQS],
    input  word_t                      core_req_data [`CACHE_NUM_REQS],
    input  req_tag_t                   core_req_tag [`CACHE_NUM_REQS],
    output logic [`CACHE_NUM_REQS-1:0] core_req_ready,

    output logic [`CACHE_NUM_REQS-1:0] core_rsp_valid,
    output word_t                      core_rsp_data [`CACHE_NUM_REQS],
    output req_tag_t                   core_rsp_tag [`CACHE_NUM_REQS],
    input  logic [`CACHE_NUM_REQS-1:0] core_rsp_ready,

    output logic                       mem_req_valid,
    output logic                       mem_req_rw,
    output mem_addr_t                  mem_req_addr,
    output line_byteen_t               mem_req_byteen,
    output line_t                      mem_req_data,
    output bank_id_t                   mem_req_tag,
    input  logic                       mem_req_ready,

    input  logic                       mem_rsp_valid,
    input  line_t                      mem_rsp_data,
    input  bank_id_t                   mem_rsp_tag,
    output logic                       mem_rsp_ready
);

    localparam int NR   = `CACHE_NUM_REQS;
    localparam int NB   = `CACHE_NUM_BANKS;
    localparam int IDX  = `CACHE_INDEX_BITS;
    localparam int BSEL = `CACHE_BANK_SEL_BITS;

    core_req_t port_req [NR];
    bank_id_t  port_bank [NR];
    core_rsp_t port_rsp [NR];

    logic [NB-1:0] bank_req_valid;
    core_req_t     bank_req [NB];
    req_idx_t      bank_req_idx [NB];
    logic [NB-1:0] bank_req_ready;

    logic [NB-1:0] bank_rsp_valid;
    core_rsp_t     bank_rsp [NB];
    req_idx_t      bank_rsp_idx [NB];
    logic [NB-1:0] bank_rsp_ready;

    logic [NB-1:0] bank_mem_valid;
    logic [NB-1:0] bank_mem_rw;
    mem_addr_t     bank_mem_addr [NB];
    mem_addr_t     bank_line_addr [NB];
    line_byteen_t  bank_mem_byteen [NB];
    line_t         bank_mem_data [NB];
    logic [NB-1:0] bank_mem_ready;

    logic [NB-1:0] bank_fill_valid;
    line_t         bank_fill_data [NB];
    logic [NB-1:0] bank_fill_ready;

    for (genvar i = 0; i < NR; i++) begin : g_port
        assign port_req[i] = '{
            rw:     core_req_rw[i],
            addr:   core_req_addr[i],
            byteen: core_req_byteen[i],
            data:   core_req_data[i],
            tag:    core_req_tag[i]
        };
        // Bank number sits just above the word select
        assign port_bank[i]     = bank_id_t'((core_req_addr[i] >> `CACHE_WORD_SEL_BITS) % NB);
        assign core_rsp_data[i] = port_rsp[i].data;
        assign core_rsp_tag[i]  = port_rsp[i].tag;
    end

    stream_xbar #(
        .NUM_INPUTS  (NR),
        .NUM_OUTPUTS (NB),
        .payload_t   (core_req_t)
    ) core_req_xbar (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (core_req_valid),
        .data_in   (port_req),
        .sel_in    (port_bank),
        .ready_in  (core_req_ready),
        .valid_out (bank_req_valid),
        .data_out  (bank_req),
        .sel_out   (bank_req_idx),
        .ready_out (bank_req_ready)
    );

    for (genvar b = 0; b < NB; b++) begin : bank
        cache_bank bank_i (
            .clk            (clk),
            .reset          (reset),
            .core_req_valid (bank_req_valid[b]),
            .core_req       (bank_req[b]),
            .core_req_idx   (bank_req_idx[b]),
            .core_req_ready (bank_req_ready[b]),
            .core_rsp_valid (bank_rsp_valid[b]),
            .core_rsp       (bank_rsp[b]),
            .core_rsp_idx   (bank_rsp_idx[b]),
            .core_rsp_ready (bank_rsp_ready[b]),
            .mem_req_valid  (bank_mem_valid[b]),
            .mem_req_rw     (bank_mem_rw[b]),
            .mem_req_addr   (bank_mem_addr[b]),
            .mem_req_byteen (bank_mem_byteen[b]),
            .mem_req_data   (bank_mem_data[b]),
            .mem_req_ready  (bank_mem_ready[b]),
            .mem_rsp_valid  (bank_fill_valid[b]),
            .mem_rsp_data   (bank_fill_data[b]),
            .mem_rsp_ready  (bank_fill_ready[b])
        );

        // Bank number goes back below the index, as in the word address
        assign bank_line_addr[b] = ((bank_mem_addr[b] >> IDX) << (IDX + BSEL))
                                 | ((bank_mem_addr[b] & mem_addr_t'((1 << IDX) - 1)) << BSEL)
                                 | mem_addr_t'(b);
    end

    stream_xbar #(
        .NUM_INPUTS  (NB),
        .NUM_OUTPUTS (NR),
        .payload_t   (core_rsp_t)
    ) core_rsp_xbar (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (bank_rsp_valid),
        .data_in   (bank_rsp),
        .sel_in    (bank_rsp_idx),
        .ready_in  (bank_rsp_ready),
        .valid_out (core_rsp_valid),
        .data_out  (port_rsp),
        .sel_out   (),
        .ready_out (core_rsp_ready)
    );

    mem_port_arb mem_arb (
        .clk             (clk),
        .reset           (reset),
        .bank_req_valid  (bank_mem_valid),
        .bank_req_rw     (bank_mem_rw),
        .bank_req_addr   (bank_line_addr),
        .bank_req_byteen (bank_mem_byteen),
        .bank_req_data   (bank_mem_data),
        .bank_req_ready  (bank_mem_ready),
        .bank_rsp_valid  (bank_fill_valid),
        .bank_rsp_data   (bank_fill_data),
        .bank_rsp_ready  (bank_fill_ready),
        .mem_req_valid   (mem_req_valid),
        .mem_req_rw      (mem_req_rw),
        .mem_req_addr    (mem_req_addr),
        .mem_req_byteen  (mem_req_byteen),
        .mem_req_data    (mem_req_data),
        .mem_req_tag     (mem_req_tag),
        .mem_req_ready   (mem_req_ready),
        .mem_rsp_valid   (mem_rsp_valid),
        .mem_rsp_data    (mem_rsp_data),
        .mem_rsp_tag     (mem_rsp_tag),
        .mem_rsp_ready   (mem_rsp_ready)
    );

endmodule

// File: bench/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Released just after a rising edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

// File: bench/banked_cache_tb.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module banked_cache_tb import cache_pkg::*; ();

    localparam int NR            = `CACHE_NUM_REQS;
    localparam int NB            = `CACHE_NUM_BANKS;
    localparam int WSEL          = `CACHE_WORD_SEL_BITS;
    localparam int BSEL          = `CACHE_BANK_SEL_BITS;
    localparam int NUM_SETS      = `CACHE_LINES_PER_BANK;
    localparam int LINE_WORDS    = `CACHE_LINE_WORDS;
    localparam int WORD_BYTES    = `CACHE_WORD_BYTES;
    localparam int NUM_TAGS      = 1 << `CACHE_TAG_WIDTH;
    localparam int MEM_WORDS     = 1 << `CACHE_ADDR_WIDTH;
    localparam int REQS_PER_PORT = 300;
    // Worst case of 20 cycles per request
    localparam int MAX_CYCLES    = REQS_PER_PORT * NR * 20;
    localparam word_t FILL_KEY   = 32'h5A3C_96E1;

    logic          clk;
    logic          reset;

    logic [NR-1:0] core_req_valid;
    logic [NR-1:0] core_req_rw;
    core_addr_t    core_req_addr [NR];
    byteen_t       core_req_byteen [NR];
    word_t         core_req_data [NR];
    req_tag_t      core_req_tag [NR];
    logic [NR-1:0] core_req_ready;

    logic [NR-1:0] core_rsp_valid;
    word_t         core_rsp_data [NR];
    req_tag_t      core_rsp_tag [NR];
    logic [NR-1:0] core_rsp_ready;

    logic          mem_req_valid;
    logic          mem_req_rw;
    mem_addr_t     mem_req_addr;
    line_byteen_t  mem_req_byteen;
    line_t         mem_req_data;
    bank_id_t      mem_req_tag;
    logic          mem_req_ready;

    logic          mem_rsp_valid;
    line_t         mem_rsp_data;
    bank_id_t      mem_rsp_tag;
    logic          mem_rsp_ready;

    // Reference and memory models
    word_t      ref_mem [MEM_WORDS];
    word_t      mem_words [MEM_WORDS];
    bank_id_t   rd_tag_q [$];
    line_t      rd_data_q [$];
    int         rd_delay;
    core_req_t  wr_q [NB][$];

    req_tag_t   free_tags [NR][$];
    logic       outstanding [NR][NUM_TAGS];
    word_t      expected [NR][NUM_TAGS];
    int         issued [NR];
    int         pending_reads;

    // Last read of each port, for the no-refetch check
    logic       last_valid [NR];
    core_addr_t last_addr [NR];
    req_tag_t   last_tag [NR];
    logic       last_done [NR];
    logic       last_clean [NR];
    logic       must_hit [NB];
    core_addr_t bank_read_addr [NB];

    logic [NR-1:0] req_fire;
    logic          mem_rsp_fire;
    logic          started;
    int            cycles;
    int            value_errors;
    int            other_errors;

    clk_gen #(.PERIOD_NS(40), .RESET_CYCLES(2)) clk_gen_i (
        .clk   (clk),
        .reset (reset)
    );

    banked_cache banked_cache_i (.*);

    function automatic int bank_of(core_addr_t a);
        return int'(a >> WSEL) % NB;
    endfunction

    function automatic int set_of(core_addr_t a);
        return int'(a >> (WSEL + BSEL)) % NUM_SETS;
    endfunction

    function automatic int line_of(core_addr_t a);
        return int'(a >> WSEL);
    endfunction

    // Memory line number is the word address without the word select
    function automatic mem_addr_t mem_line_of(core_addr_t a);
        return mem_addr_t'(a >> WSEL);
    endfunction

    function automatic int core_base_of(mem_addr_t m);
        return int'(m) << WSEL;
    endfunction

    function automatic logic run_finished();
        logic busy;
        busy = (core_req_valid != '0) || (pending_reads != 0) || mem_rsp_valid
            || (rd_tag_q.size() != 0);
        for (int p = 0; p < NR; p++) begin
            busy = busy || (issued[p] < REQS_PER_PORT);
        end
        for (int b = 0; b < NB; b++) begin
            busy = busy || (wr_q[b].size() != 0);
        end
        return !busy;
    endfunction

    task automatic value_mismatch(string name, logic [127:0] exp, logic [127:0] act);
        value_errors++;
        $display("ERR %0t %s: expected %0h, got %0h", $time, name, exp, act);
    endtask

    task automatic report_failure(string what);
        other_errors++;
        $display("%0t: %s", $time, what);
    endtask

    // Samples one cycle's transfers before the coming edge
    task automatic check_cycle();
        int p;
        int q;
        int t;
        int b;
        int i;
        int wd;
        int base;
        core_addr_t a;
        core_req_t w;
        line_byteen_t exp_be;
        line_t fill;
        if (!started) begin
            assert (core_rsp_valid == '0 && !mem_req_valid) else
                report_failure("response or memory request valid before any request");
        end
        for (p = 0; p < NR; p++) begin
            if (core_rsp_valid[p] && core_rsp_ready[p]) begin
                t = int'(core_rsp_tag[p]);
                assert (outstanding[p][t]) else
                    report_failure($sformatf("port %0d answered tag %0d, which is not outstanding",
                                             p, t));
                if (outstanding[p][t]) begin
                    assert (core_rsp_data[p] == expected[p][t]) else
                        value_mismatch($sformatf("core_rsp_data[%0d] tag %0d", p, t),
                                       expected[p][t], core_rsp_data[p]);
                    outstanding[p][t] = 1'b0;
                    pending_reads--;
                    free_tags[p].push_back(req_tag_t'(t));
                    if (last_valid[p] && int'(last_tag[p]) == t) begin
                        last_done[p] = 1'b1;
                    end
                end
            end
        end
        if (mem_rsp_valid && mem_rsp_ready) begin
            mem_rsp_fire = 1'b1;
            void'(rd_tag_q.pop_front());
            void'(rd_data_q.pop_front());
        end else begin
            mem_rsp_fire = 1'b0;
        end
        if (mem_req_valid && mem_req_ready) begin
            b    = int'(mem_req_tag);
            base = core_base_of(mem_req_addr);
            if (mem_req_rw) begin
                assert (wr_q[b].size() > 0) else
                    report_failure($sformatf("memory write from bank %0d with no core write", b));
                if (wr_q[b].size() > 0) begin
                    w = wr_q[b].pop_front();
                    exp_be = '0;
                    exp_be[w.addr[WSEL-1:0]] = w.byteen;
                    assert (mem_req_addr == mem_line_of(w.addr)) else
                        value_mismatch("mem_req_addr", mem_line_of(w.addr), mem_req_addr);
                    assert (mem_req_byteen == exp_be) else
                        value_mismatch("mem_req_byteen", exp_be, mem_req_byteen);
                    for (i = 0; i < WORD_BYTES; i++) begin
                        if (w.byteen[i]) begin
                            assert (mem_req_data[w.addr[WSEL-1:0]][i*8 +: 8] == w.data[i*8 +: 8])
                            else
                                value_mismatch($sformatf("mem_req_data byte %0d", i),
                                               w.data[i*8 +: 8],
                                               mem_req_data[w.addr[WSEL-1:0]][i*8 +: 8]);
                        end
                    end
                end
                for (wd = 0; wd < LINE_WORDS; wd++) begin
                    for (i = 0; i < WORD_BYTES; i++) begin
                        if (mem_req_byteen[wd][i]) begin
                            mem_words[base + wd][i*8 +: 8] = mem_req_data[wd][i*8 +: 8];
                        end
                    end
                end
            end else begin
                assert (!must_hit[b]) else
                    report_failure($sformatf("bank %0d fetched a line it already held", b));
                assert (mem_req_addr == mem_line_of(bank_read_addr[b])) else
                    value_mismatch("mem_req_addr", mem_line_of(bank_read_addr[b]), mem_req_addr);
                for (wd = 0; wd < LINE_WORDS; wd++) begin
                    fill[wd] = mem_words[base + wd];
                end
                if (rd_tag_q.size() == 0) begin
                    rd_delay = 1 + $urandom_range(3);
                end
                rd_tag_q.push_back(mem_req_tag);
                rd_data_q.push_back(fill);
            end
        end
        for (p = 0; p < NR; p++) begin
            req_fire[p] = core_req_valid[p] && core_req_ready[p];
            if (req_fire[p]) begin
                started = 1'b1;
                a = core_req_addr[p];
                b = bank_of(a);
                for (q = 0; q < NR; q++) begin
                    if (last_valid[q] && core_req_rw[p] && line_of(last_addr[q]) == line_of(a)) begin
                        last_clean[q] = 1'b0;
                    end
                    if (last_valid[q] && !core_req_rw[p] && line_of(last_addr[q]) != line_of(a)
                            && bank_of(last_addr[q]) == b && set_of(last_addr[q]) == set_of(a)) begin
                        last_clean[q] = 1'b0;
                    end
                end
                if (core_req_rw[p]) begin
                    for (i = 0; i < WORD_BYTES; i++) begin
                        if (core_req_byteen[p][i]) begin
                            ref_mem[a][i*8 +: 8] = core_req_data[p][i*8 +: 8];
                        end
                    end
                    w.rw     = 1'b1;
                    w.addr   = a;
                    w.byteen = core_req_byteen[p];
                    w.data   = core_req_data[p];
                    w.tag    = core_req_tag[p];
                    wr_q[b].push_back(w);
                    must_hit[b] = 1'b0;
                end else begin
                    t = int'(core_req_tag[p]);
                    expected[p][t]    = ref_mem[a];
                    outstanding[p][t] = 1'b1;
                    pending_reads++;
                    must_hit[b] = last_valid[p] && last_done[p] && last_clean[p]
                               && line_of(last_addr[p]) == line_of(a);
                    bank_read_addr[b] = a;
                    last_valid[p] = 1'b1;
                    last_addr[p]  = a;
                    last_tag[p]   = core_req_tag[p];
                    last_done[p]  = 1'b0;
                    last_clean[p] = 1'b1;
                end
            end
        end
    endtask

    task automatic new_request(int p);
        int off;
        logic is_read;
        if (free_tags[p].size() == 0) begin
            return;
        end
        off     = $urandom_range(63);
        is_read = ($urandom_range(99) < 60);
        // 64 words, two lines competing for each used set
        core_req_addr[p]   = core_addr_t'(((off >> 5) << 8) | (off & 31));
        core_req_rw[p]     = !is_read;
        core_req_byteen[p] = byteen_t'($urandom_range(15, 1));
        core_req_data[p]   = $urandom();
        if (is_read) begin
            core_req_tag[p] = free_tags[p].pop_front();
        end else begin
            core_req_tag[p] = free_tags[p][0];
        end
        core_req_valid[p] = 1'b1;
        issued[p]++;
    endtask

    task automatic drive_cycle();
        for (int p = 0; p < NR; p++) begin
            if (req_fire[p]) begin
                core_req_valid[p] = 1'b0;
            end
            if (!core_req_valid[p] && issued[p] < REQS_PER_PORT && cycles >= 3
                    && $urandom_range(99) < 80) begin
                new_request(p);
            end
            core_rsp_ready[p] = ($urandom_range(99) >= 25);
        end
        mem_req_ready = ($urandom_range(99) >= 25);
        if (mem_rsp_fire) begin
            mem_rsp_valid = 1'b0;
            rd_delay = 1 + $urandom_range(3);
        end
        if (!mem_rsp_valid && rd_tag_q.size() > 0) begin
            if (rd_delay <= 1) begin
                mem_rsp_valid = 1'b1;
                mem_rsp_tag   = rd_tag_q[0];
                mem_rsp_data  = rd_data_q[0];
            end else begin
                rd_delay--;
            end
        end
    endtask

    initial begin
        void'($urandom(5));
        core_req_valid = '0;
        core_req_rw    = '0;
        core_rsp_ready = '0;
        mem_req_ready  = 1'b0;
        mem_rsp_valid  = 1'b0;
        mem_rsp_data   = '0;
        mem_rsp_tag    = '0;
        for (int p = 0; p < NR; p++) begin
            core_req_addr[p]   = '0;
            core_req_byteen[p] = '0;
            core_req_data[p]   = '0;
            core_req_tag[p]    = '0;
            issued[p]     = 0;
            last_valid[p] = 1'b0;
            last_done[p]  = 1'b0;
            last_clean[p] = 1'b0;
            last_addr[p]  = '0;
            last_tag[p]   = '0;
            for (int t = 0; t < NUM_TAGS; t++) begin
                outstanding[p][t] = 1'b0;
                expected[p][t]    = '0;
                free_tags[p].push_back(req_tag_t'(t));
            end
        end
        for (int b = 0; b < NB; b++) begin
            must_hit[b]       = 1'b0;
            bank_read_addr[b] = '0;
        end
        for (int a = 0; a < MEM_WORDS; a++) begin
            ref_mem[a]   = word_t'(a) ^ FILL_KEY;
            mem_words[a] = word_t'(a) ^ FILL_KEY;
        end
        req_fire      = '0;
        mem_rsp_fire  = 1'b0;
        rd_delay      = 1;
        pending_reads = 0;
        started       = 1'b0;
        cycles        = 0;
        value_errors  = 0;
        other_errors  = 0;

        wait (!reset);
        while (!run_finished() && cycles < MAX_CYCLES) begin
            @(negedge clk);
            check_cycle();
            @(posedge clk);
            #1;
            drive_cycle();
            cycles++;
        end

        if (!run_finished()) begin
            report_failure($sformatf("timeout, run not finished after %0d cycles", MAX_CYCLES));
        end
        assert (pending_reads == 0) else
            report_failure($sformatf("%0d reads never got a response", pending_reads));

        $display("Checks done after %0d cycles: %0d value errors, %0d other errors",
                 cycles, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+src
src/cache_pkg.sv
src/stream_xbar.sv
src/cache_bank.sv
src/mem_port_arb.sv
src/banked_cache.sv
bench/clk_gen.sv
bench/banked_cache_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= banked_cache_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
